// File: include/core_pkg.sv
package core_pkg;

    localparam int num_lanes  = 2;
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int wen_w      = 4;

    // pc reported on the trace ports out of reset
    localparam logic [xlen-1:0] reset_pc = 32'h1C00_0000;

    // three-register formats, inst[31:15]
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_slt   = 17'h00024;
    localparam logic [16:0] op_sltu  = 17'h00025;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002A;
    localparam logic [16:0] op_xor   = 17'h0002B;
    localparam logic [16:0] op_sll_w = 17'h0002E;
    localparam logic [16:0] op_srl_w = 17'h0002F;

    // register plus 12-bit immediate, inst[31:22]
    localparam logic [9:0] op_slti   = 10'h008;
    localparam logic [9:0] op_sltui  = 10'h009;
    localparam logic [9:0] op_addi_w = 10'h00A;
    localparam logic [9:0] op_andi   = 10'h00D;
    localparam logic [9:0] op_ori    = 10'h00E;
    localparam logic [9:0] op_xori   = 10'h00F;

    typedef enum logic [3:0] {
        alu_none,
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl
    } alu_op_e;

    typedef struct packed {
        logic [16:0]           opcode;
        logic [reg_addr_w-1:0] rk;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rd;
    } inst_3r_t;

    typedef struct packed {
        logic [9:0]            opcode;
        logic [11:0]           imm;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rd;
    } inst_2ri12_t;

    // rj and rd sit at the same bits in both views
    typedef union packed {
        inst_3r_t    r3;
        inst_2ri12_t ri12;
    } inst_word_u;

endpackage

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                                                     aclk,
    input  logic                                                     aresetn,
    input  logic [core_pkg::num_lanes-1:0]                           i_we,
    input  logic [core_pkg::num_lanes-1:0][core_pkg::reg_addr_w-1:0] i_waddr,
    input  logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       i_wdata,
    input  logic [2*core_pkg::num_lanes-1:0][core_pkg::reg_addr_w-1:0] i_raddr,
    output logic [2*core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]     o_rdata
);
    import core_pkg::*;

    // r0 has no storage
    logic [xlen-1:0] regs [1:num_regs-1];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int r = 1; r < num_regs; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // later lane overrides on the same address
            for (int l = 0; l < num_lanes; l++) begin
                if (i_we[l] && i_waddr[l] != '0) begin
                    regs[i_waddr[l]] <= i_wdata[l];
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2*num_lanes; p++) begin
            if (i_raddr[p] == '0) begin
                o_rdata[p] = '0;
            end else begin
                o_rdata[p] = regs[i_raddr[p]];
                // write-first, lane 1 checked last
                for (int l = 0; l < num_lanes; l++) begin
                    if (i_we[l] && i_waddr[l] == i_raddr[p]) begin
                        o_rdata[p] = i_wdata[l];
                    end
                end
            end
        end
    end

endmodule

// File: logic/exec_lane.sv
`timescale 1ns/1ps

module exec_lane (
    input  logic                            aclk,
    input  logic                            aresetn,
    input  logic                            i_valid,
    input  core_pkg::alu_op_e               i_alu_op,
    input  logic [core_pkg::xlen-1:0]       i_opa,
    input  logic [core_pkg::xlen-1:0]       i_opb,
    input  logic [core_pkg::reg_addr_w-1:0] i_rd,
    input  logic [core_pkg::xlen-1:0]       i_pc,
    input  logic [core_pkg::xlen-1:0]       i_inst,
    output logic                            o_fwd_valid,
    output logic [core_pkg::reg_addr_w-1:0] o_fwd_rd,
    output logic [core_pkg::xlen-1:0]       o_fwd_data,
    output logic                            o_valid,
    output logic                            o_we,
    output logic [core_pkg::reg_addr_w-1:0] o_rd,
    output logic [core_pkg::xlen-1:0]       o_result,
    output logic [core_pkg::xlen-1:0]       o_pc,
    output logic [core_pkg::xlen-1:0]       o_inst
);
    import core_pkg::*;

    logic [xlen-1:0]          result;
    logic [$clog2(xlen)-1:0]  shamt;
    logic                     we;

    // only the low bits count as shift amount
    assign shamt = i_opb[$clog2(xlen)-1:0];

    always_comb begin
        case (i_alu_op)
            alu_add:  result = i_opa + i_opb;
            alu_sub:  result = i_opa - i_opb;
            alu_and:  result = i_opa & i_opb;
            alu_or:   result = i_opa | i_opb;
            alu_xor:  result = i_opa ^ i_opb;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(i_opa) < $signed(i_opb)};
            alu_sltu: result = {{(xlen-1){1'b0}}, i_opa < i_opb};
            alu_sll:  result = i_opa << shamt;
            alu_srl:  result = i_opa >> shamt;
            default:  result = '0;
        endcase
    end

    // unknown words and r0 targets retire without a write
    assign we = i_valid && i_alu_op != alu_none && i_rd != '0;

    assign o_fwd_valid = we;
    assign o_fwd_rd    = i_rd;
    assign o_fwd_data  = result;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_valid <= 1'b0;
            o_we    <= 1'b0;
        end else begin
            o_valid <= i_valid;
            o_we    <= we;
        end
    end

    always_ff @(posedge aclk) begin
        o_rd     <= i_rd;
        o_result <= result;
        o_pc     <= i_pc;
        o_inst   <= i_inst;
    end

endmodule

// File: logic/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
    input  logic                                                     aclk,
    input  logic                                                     aresetn,
    input  logic [core_pkg::num_lanes-1:0]                           i_valid,
    input  logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       i_inst,
    input  logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       i_pc,
    input  logic [core_pkg::num_lanes-1:0]                           i_fwd_valid,
    input  logic [core_pkg::num_lanes-1:0][core_pkg::reg_addr_w-1:0] i_fwd_rd,
    input  logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       i_fwd_data,
    input  logic [core_pkg::num_lanes-1:0]                           i_wb_we,
    input  logic [core_pkg::num_lanes-1:0][core_pkg::reg_addr_w-1:0] i_wb_waddr,
    input  logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       i_wb_wdata,
    output logic [core_pkg::num_lanes-1:0]                           o_valid,
    output core_pkg::alu_op_e [core_pkg::num_lanes-1:0]              o_alu_op,
    output logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       o_opa,
    output logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       o_opb,
    output logic [core_pkg::num_lanes-1:0][core_pkg::reg_addr_w-1:0] o_rd,
    output logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       o_pc,
    output logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       o_inst
);
    import core_pkg::*;

    // port 2*l is rj of lane l, port 2*l+1 is rk
    logic [2*num_lanes-1:0][reg_addr_w-1:0] rf_raddr;
    logic [2*num_lanes-1:0][xlen-1:0]       rf_rdata;
    logic [2*num_lanes-1:0][xlen-1:0]       src_val;

    alu_op_e [num_lanes-1:0]                dec_op;
    logic [num_lanes-1:0][xlen-1:0]         dec_opb;
    logic [num_lanes-1:0][reg_addr_w-1:0]   dec_rd;

    always_comb begin
        inst_word_u word;
        for (int l = 0; l < num_lanes; l++) begin
            word = i_inst[l];
            rf_raddr[2*l]   = word.r3.rj;
            rf_raddr[2*l+1] = word.r3.rk;
        end
    end

    register_file u_register_file (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_we    (i_wb_we),
        .i_waddr (i_wb_waddr),
        .i_wdata (i_wb_wdata),
        .i_raddr (rf_raddr),
        .o_rdata (rf_rdata)
    );

    // oldest source first so younger results overwrite
    always_comb begin
        for (int p = 0; p < 2*num_lanes; p++) begin
            src_val[p] = rf_rdata[p];
            for (int l = 0; l < num_lanes; l++) begin
                if (i_wb_we[l] && i_wb_waddr[l] == rf_raddr[p]) begin
                    src_val[p] = i_wb_wdata[l];
                end
            end
            for (int l = 0; l < num_lanes; l++) begin
                if (i_fwd_valid[l] && i_fwd_rd[l] == rf_raddr[p]) begin
                    src_val[p] = i_fwd_data[l];
                end
            end
        end
    end

    always_comb begin
        inst_word_u word;
        for (int l = 0; l < num_lanes; l++) begin
            word       = i_inst[l];
            dec_rd[l]  = word.r3.rd;
            dec_opb[l] = src_val[2*l+1];
            case (word.r3.opcode)
                op_add_w: dec_op[l] = alu_add;
                op_sub_w: dec_op[l] = alu_sub;
                op_and:   dec_op[l] = alu_and;
                op_or:    dec_op[l] = alu_or;
                op_xor:   dec_op[l] = alu_xor;
                op_slt:   dec_op[l] = alu_slt;
                op_sltu:  dec_op[l] = alu_sltu;
                op_sll_w: dec_op[l] = alu_sll;
                op_srl_w: dec_op[l] = alu_srl;
                default:  dec_op[l] = alu_none;
            endcase
            // not a three-register word, try the immediate view
            if (dec_op[l] == alu_none) begin
                case (word.ri12.opcode)
                    op_addi_w: dec_op[l] = alu_add;
                    op_slti:   dec_op[l] = alu_slt;
                    op_sltui:  dec_op[l] = alu_sltu;
                    op_andi:   dec_op[l] = alu_and;
                    op_ori:    dec_op[l] = alu_or;
                    op_xori:   dec_op[l] = alu_xor;
                    default:   dec_op[l] = alu_none;
                endcase
                // logical immediates are zero-extended
                if (word.ri12.opcode inside {op_andi, op_ori, op_xori}) begin
                    dec_opb[l] = {{(xlen-12){1'b0}}, word.ri12.imm};
                end else begin
                    dec_opb[l] = {{(xlen-12){word.ri12.imm[11]}}, word.ri12.imm};
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_valid <= '0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge aclk) begin
        o_alu_op <= dec_op;
        o_opb    <= dec_opb;
        o_rd     <= dec_rd;
        o_pc     <= i_pc;
        o_inst   <= i_inst;
        for (int l = 0; l < num_lanes; l++) begin
            o_opa[l] <= src_val[2*l];
        end
    end

endmodule

// File: logic/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic                                                     aclk,
    input  logic                                                     aresetn,
    input  logic [core_pkg::num_lanes-1:0]                           i_valid,
    input  logic [core_pkg::num_lanes-1:0]                           i_we,
    input  logic [core_pkg::num_lanes-1:0][core_pkg::reg_addr_w-1:0] i_rd,
    input  logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       i_result,
    input  logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       i_pc,
    input  logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       i_inst,
    output logic [core_pkg::num_lanes-1:0]                           o_rf_we,
    output logic [core_pkg::num_lanes-1:0][core_pkg::reg_addr_w-1:0] o_rf_waddr,
    output logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       o_rf_wdata,
    output logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       o_wb_pc,
    output logic [core_pkg::num_lanes-1:0][core_pkg::wen_w-1:0]      o_wb_rf_wen,
    output logic [core_pkg::num_lanes-1:0][core_pkg::reg_addr_w-1:0] o_wb_rf_wnum,
    output logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       o_wb_rf_wdata,
    output logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       o_wb_inst
);
    import core_pkg::*;

    // register file sees the write in the same cycle as the trace update
    assign o_rf_we    = i_we & i_valid;
    assign o_rf_waddr = i_rd;
    assign o_rf_wdata = i_result;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int l = 0; l < num_lanes; l++) begin
                o_wb_pc[l]       <= reset_pc;
                o_wb_rf_wen[l]   <= '0;
                o_wb_rf_wnum[l]  <= '0;
                o_wb_rf_wdata[l] <= '0;
                o_wb_inst[l]     <= '0;
            end
        end else begin
            for (int l = 0; l < num_lanes; l++) begin
                // byte enables, all or nothing
                o_wb_rf_wen[l] <= {wen_w{i_valid[l] & i_we[l]}};
                if (i_valid[l]) begin
                    o_wb_pc[l]       <= i_pc[l];
                    o_wb_rf_wnum[l]  <= i_rd[l];
                    o_wb_rf_wdata[l] <= i_result[l];
                    o_wb_inst[l]     <= i_inst[l];
                end
            end
        end
    end

endmodule

// File: logic/core_backend.sv
`timescale 1ns/1ps

module core_backend (
    input  logic                                                     aclk,
    input  logic                                                     aresetn,
    input  logic [core_pkg::num_lanes-1:0]                           i_valid,
    input  logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       i_inst,
    input  logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       i_pc,
    output logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       o_wb_pc,
    output logic [core_pkg::num_lanes-1:0][core_pkg::wen_w-1:0]      o_wb_rf_wen,
    output logic [core_pkg::num_lanes-1:0][core_pkg::reg_addr_w-1:0] o_wb_rf_wnum,
    output logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       o_wb_rf_wdata,
    output logic [core_pkg::num_lanes-1:0][core_pkg::xlen-1:0]       o_wb_inst
);
    import core_pkg::*;

    // issue to lanes
    logic [num_lanes-1:0]                 iss_valid;
    alu_op_e [num_lanes-1:0]              iss_alu_op;
    logic [num_lanes-1:0][xlen-1:0]       iss_opa;
    logic [num_lanes-1:0][xlen-1:0]       iss_opb;
    logic [num_lanes-1:0][reg_addr_w-1:0] iss_rd;
    logic [num_lanes-1:0][xlen-1:0]       iss_pc;
    logic [num_lanes-1:0][xlen-1:0]       iss_inst;

    // lane bypass back to issue
    logic [num_lanes-1:0]                 fwd_valid;
    logic [num_lanes-1:0][reg_addr_w-1:0] fwd_rd;
    logic [num_lanes-1:0][xlen-1:0]       fwd_data;

    // lanes to writeback
    logic [num_lanes-1:0]                 ex_valid;
    logic [num_lanes-1:0]                 ex_we;
    logic [num_lanes-1:0][reg_addr_w-1:0] ex_rd;
    logic [num_lanes-1:0][xlen-1:0]       ex_result;
    logic [num_lanes-1:0][xlen-1:0]       ex_pc;
    logic [num_lanes-1:0][xlen-1:0]       ex_inst;

    // writeback to register file
    logic [num_lanes-1:0]                 rf_we;
    logic [num_lanes-1:0][reg_addr_w-1:0] rf_waddr;
    logic [num_lanes-1:0][xlen-1:0]       rf_wdata;

    issue_stage u_issue_stage (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_valid     (i_valid),
        .i_inst      (i_inst),
        .i_pc        (i_pc),
        .i_fwd_valid (fwd_valid),
        .i_fwd_rd    (fwd_rd),
        .i_fwd_data  (fwd_data),
        .i_wb_we     (rf_we),
        .i_wb_waddr  (rf_waddr),
        .i_wb_wdata  (rf_wdata),
        .o_valid     (iss_valid),
        .o_alu_op    (iss_alu_op),
        .o_opa       (iss_opa),
        .o_opb       (iss_opb),
        .o_rd        (iss_rd),
        .o_pc        (iss_pc),
        .o_inst      (iss_inst)
    );

    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        exec_lane u_exec_lane (
            .aclk        (aclk),
            .aresetn     (aresetn),
            .i_valid     (iss_valid[g]),
            .i_alu_op    (iss_alu_op[g]),
            .i_opa       (iss_opa[g]),
            .i_opb       (iss_opb[g]),
            .i_rd        (iss_rd[g]),
            .i_pc        (iss_pc[g]),
            .i_inst      (iss_inst[g]),
            .o_fwd_valid (fwd_valid[g]),
            .o_fwd_rd    (fwd_rd[g]),
            .o_fwd_data  (fwd_data[g]),
            .o_valid     (ex_valid[g]),
            .o_we        (ex_we[g]),
            .o_rd        (ex_rd[g]),
            .o_result    (ex_result[g]),
            .o_pc        (ex_pc[g]),
            .o_inst      (ex_inst[g])
        );
    end

    writeback_stage u_writeback_stage (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_valid       (ex_valid),
        .i_we          (ex_we),
        .i_rd          (ex_rd),
        .i_result      (ex_result),
        .i_pc          (ex_pc),
        .i_inst        (ex_inst),
        .o_rf_we       (rf_we),
        .o_rf_waddr    (rf_waddr),
        .o_rf_wdata    (rf_wdata),
        .o_wb_pc       (o_wb_pc),
        .o_wb_rf_wen   (o_wb_rf_wen),
        .o_wb_rf_wnum  (o_wb_rf_wnum),
        .o_wb_rf_wdata (o_wb_rf_wdata),
        .o_wb_inst     (o_wb_inst)
    );

endmodule

// File: include/tb_vectors.svh
task automatic load_vectors();
    // per row the valid bits and then word, write flag and data of each lane
    // sign and zero extended immediates
    add_row(2'b11, enc_ri(op_addi_w, 1, 0, 'h123), 1, 'h00000123,
                   enc_ri(op_addi_w, 2, 0, 'hfff), 1, 'hffffffff);
    add_row(2'b11, enc_ri(op_andi, 3, 2, 'hf0f), 1, 'h00000f0f,
                   enc_ri(op_ori, 4, 1, 'h800), 1, 'h00000923);
    add_row(2'b11, enc_ri(op_xori, 5, 2, 'hfff), 1, 'hfffff000,
                   enc_ri(op_slti, 6, 2, 'h000), 1, 'h00000001);
    add_row(2'b11, enc_ri(op_sltui, 7, 5, 'hfff), 1, 'h00000001,
                   enc_ri(op_slti, 8, 1, 'h800), 1, 'h00000000);
    // three-register forms
    add_row(2'b11, enc_3r(op_add_w, 9, 1, 4), 1, 'h00000a46,
                   enc_3r(op_sub_w, 10, 1, 4), 1, 'hfffff800);
    add_row(2'b11, enc_3r(op_or, 11, 3, 4), 1, 'h00000f2f,
                   enc_3r(op_xor, 12, 2, 4), 1, 'hfffff6dc);
    add_row(2'b11, enc_3r(op_and, 13, 12, 3), 1, 'h0000060c,
                   enc_3r(op_slt, 14, 2, 1), 1, 'h00000001);
    // shift amounts from the low 5 bits only
    add_row(2'b11, enc_3r(op_sltu, 15, 2, 1), 1, 'h00000000,
                   enc_3r(op_sll_w, 16, 1, 9), 1, 'h000048c0);
    add_row(2'b11, enc_3r(op_srl_w, 17, 2, 12), 1, 'h0000000f,
                   enc_ri(op_addi_w, 0, 1, 'h007), 0, 'h00000000);
    // lane 1 sees r20 from before the pair
    add_row(2'b11, enc_ri(op_addi_w, 20, 0, 'h005), 1, 'h00000005,
                   enc_3r(op_add_w, 21, 20, 0), 1, 'h00000000);
    add_row(2'b11, enc_ri(op_addi_w, 22, 0, 'h011), 1, 'h00000011,
                   enc_ri(op_addi_w, 22, 0, 'h022), 1, 'h00000022);
    // unknown word on lane 1 with r1 in its rd field
    add_row(2'b11, enc_3r(op_add_w, 23, 22, 20), 1, 'h00000027,
                   'hffffffe1, 0, 'h00000000);
    add_row(2'b01, enc_3r(op_add_w, 24, 0, 16), 1, 'h000048c0,
                   'h00000000, 0, 'h00000000);
    // r1 still holds its old value
    add_row(2'b11, enc_ri(op_addi_w, 25, 1, 'h001), 1, 'h00000124,
                   enc_3r(op_sub_w, 26, 9, 10), 1, 'h00001246);
endtask

// File: verif/core_backend_tb.sv
`timescale 1ns/1ps

module core_backend_tb;
    import core_pkg::*;

    localparam int reset_cycles = 5;
    // falling edges from driving a pair to its trace
    localparam int latency = 3;

    typedef struct packed {
        logic [num_lanes-1:0]           valid;
        logic [num_lanes-1:0]           wr;
        logic [num_lanes-1:0][xlen-1:0] inst;
        logic [num_lanes-1:0][xlen-1:0] pc;
        logic [num_lanes-1:0][xlen-1:0] data;
    } row_t;

    logic                                 aclk;
    logic                                 aresetn;
    logic [num_lanes-1:0]                 valid;
    logic [num_lanes-1:0][xlen-1:0]       inst;
    logic [num_lanes-1:0][xlen-1:0]       pc;
    logic [num_lanes-1:0][xlen-1:0]       wb_pc;
    logic [num_lanes-1:0][wen_w-1:0]      wb_wen;
    logic [num_lanes-1:0][reg_addr_w-1:0] wb_wnum;
    logic [num_lanes-1:0][xlen-1:0]       wb_wdata;
    logic [num_lanes-1:0][xlen-1:0]       wb_inst;

    row_t rows [$];
    int   due_row [$];
    int   due_cycle [$];
    int   cycle;
    int   max_cycles;
    int   checks;
    int   errors;

    core_backend dut_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_valid       (valid),
        .i_inst        (inst),
        .i_pc          (pc),
        .o_wb_pc       (wb_pc),
        .o_wb_rf_wen   (wb_wen),
        .o_wb_rf_wnum  (wb_wnum),
        .o_wb_rf_wdata (wb_wdata),
        .o_wb_inst     (wb_inst)
    );

    always #50 aclk = ~aclk;

    function automatic logic [xlen-1:0] enc_3r(logic [16:0] op, logic [4:0] rd, rj, rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [xlen-1:0] enc_ri(logic [9:0] op, logic [4:0] rd, rj,
                                               logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    task automatic add_row(logic [num_lanes-1:0] v, logic [xlen-1:0] inst0, logic wr0,
                           logic [xlen-1:0] data0, logic [xlen-1:0] inst1, logic wr1,
                           logic [xlen-1:0] data1);
        row_t            r;
        logic [xlen-1:0] base;
        // pcs count up from the reset pc, 8 bytes per pair
        base    = reset_pc + xlen'(8 * rows.size());
        r.valid = v;
        r.wr    = {wr1, wr0};
        r.inst  = {inst1, inst0};
        r.pc    = {base + 32'd4, base};
        r.data  = {data1, data0};
        rows.push_back(r);
    endtask

    `include "tb_vectors.svh"

    task automatic check_reset_state();
        for (int l = 0; l < num_lanes; l++) begin
            checks++;
            assert (wb_wen[l] == '0 && wb_pc[l] == reset_pc) else begin
                errors++;
                $display("MISMATCH at %0t: lane %0d out of reset wen %h pc %h",
                         $time, l, wb_wen[l], wb_pc[l]);
            end
        end
    endtask

    task automatic check_trace(int idx);
        row_t             r;
        logic [wen_w-1:0] exp_wen;
        r = rows[idx];
        for (int l = 0; l < num_lanes; l++) begin
            exp_wen = {wen_w{r.valid[l] & r.wr[l]}};
            checks++;
            assert (wb_wen[l] == exp_wen) else begin
                errors++;
                $display("MISMATCH at %0t: row %0d lane %0d wen %h, expected %h",
                         $time, idx, l, wb_wen[l], exp_wen);
            end
            // an idle slot leaves pc and inst alone
            if (r.valid[l]) begin
                assert (wb_pc[l] == r.pc[l] && wb_inst[l] == r.inst[l]) else begin
                    errors++;
                    $display("MISMATCH at %0t: row %0d lane %0d pc %h inst %h, expected %h %h",
                             $time, idx, l, wb_pc[l], wb_inst[l], r.pc[l], r.inst[l]);
                end
            end
            if (exp_wen != '0) begin
                assert (wb_wnum[l] == r.inst[l][4:0] && wb_wdata[l] == r.data[l]) else begin
                    errors++;
                    $display("MISMATCH at %0t: row %0d lane %0d r%0d = %h, expected r%0d = %h",
                             $time, idx, l, wb_wnum[l], wb_wdata[l], r.inst[l][4:0], r.data[l]);
                end
            end
        end
    endtask

    always @(negedge aclk) begin
        if (due_cycle.size() > 0 && due_cycle[0] == cycle) begin
            void'(due_cycle.pop_front());
            check_trace(due_row.pop_front());
        end
    end

    // cycle counter, stops the run at the limit
    initial begin
        cycle = 0;
        while (max_cycles == 0 || cycle < max_cycles) begin
            @(posedge aclk);
            cycle++;
        end
        $display("timeout after %0d cycles, %0d pairs never reached the trace ports",
                 cycle, due_row.size());
        $display("Finished with errors");
        $finish;
    end

    initial begin
        row_t cur;
        int   gap;
        void'($urandom(43));
        aclk    = 1'b0;
        aresetn = 1'b0;
        valid   = '0;
        inst    = '0;
        pc      = '0;
        checks  = 0;
        errors  = 0;
        load_vectors();
        max_cycles = rows.size() * 4 + reset_cycles + 20;
        repeat (reset_cycles) begin
            @(negedge aclk);
            check_reset_state();
        end
        aresetn = 1'b1;
        @(negedge aclk);
        check_reset_state();
        foreach (rows[r]) begin
            gap   = $urandom % 4;
            valid = '0;
            inst  = '0;
            repeat (gap) begin
                @(negedge aclk);
            end
            cur   = rows[r];
            valid = cur.valid;
            inst  = cur.inst;
            pc    = cur.pc;
            due_row.push_back(r);
            due_cycle.push_back(cycle + latency);
            @(negedge aclk);
        end
        valid = '0;
        inst  = '0;
        while (due_row.size() > 0) begin
            @(negedge aclk);
        end
        $display("lane checks: %0d, mismatches: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
include/core_pkg.sv
logic/register_file.sv
logic/exec_lane.sv
logic/issue_stage.sv
logic/writeback_stage.sv
logic/core_backend.sv
verif/core_backend_tb.sv

// File: Bender.yml
package:
  name: core_backend

sources:
  - include_dirs:
      - include
    files:
      - include/core_pkg.sv
      - logic/register_file.sv
      - logic/exec_lane.sv
      - logic/issue_stage.sv
      - logic/writeback_stage.sv
      - logic/core_backend.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/core_backend_tb.sv
